//--- source/window_pkg.sv
`default_nettype none

// ****************************************
// pixel window geometry
// ****************************************
package window_pkg;

	// camera frame, fixed size
	localparam int FRAME_WIDTH  = 10; // pixels per line
	localparam int FRAME_HEIGHT = 6;  // lines per frame

	// haar window
	localparam int WIN_W = 3; // window columns
	localparam int WIN_H = 3; // window rows, also number of line rows

	// ****************************************
	// data widths
	// ****************************************
	localparam int PIXEL_W = 8;  // raw camera pixel
	localparam int SUM_W   = 12; // integral value, 9 x 255 = 2295 fits

	// flat index of an integral output is y*WIN_W + x
	localparam int WIN_N = WIN_W * WIN_H;

endpackage

`default_nettype wire

//--- source/ctrl_pkg.sv
`default_nettype none

// ****************************************
// fill controller types
// ****************************************
package ctrl_pkg;

	// controller states
	typedef enum logic [1:0] {
		FILL_IDLE   = 2'd0, // waiting for start of frame
		FILL_LINES  = 2'd1, // first WIN_H-1 lines entering the line rows
		FILL_STREAM = 2'd2  // windows may be valid
	} fill_state_e;

	// frame position counters
	localparam int COL_W = 4; // column 0..9
	localparam int ROW_W = 3; // row 0..5

endpackage

`default_nettype wire

//--- source/line_row.sv
`timescale 1ns/10ps
`default_nettype none

module line_row
	import window_pkg::*;
(
	input  logic               i_clk,
	input  logic               i_reset,
	input  logic               i_wen,
	input  logic [PIXEL_W-1:0] i_pixel,                // pixel entering this row
	input  logic [SUM_W-1:0]   i_col_sum [WIN_W],      // sums of older rows, per column
	output logic [PIXEL_W-1:0] o_tap_out,              // pixel one line earlier
	output logic [SUM_W-1:0]   o_row_integral [WIN_W]  // integral values of this row
);

	// ****************************************
	// line delay
	// ****************************************
	logic [PIXEL_W-1:0] line_sr [FRAME_WIDTH]; // index 0 newest
	logic [PIXEL_W-1:0] taps [WIN_W];          // window taps, index 0 oldest
	logic [SUM_W-1:0]   acc;                   // running horizontal sum

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			for (int k = 0; k < FRAME_WIDTH; k++)
				line_sr[k] <= '0;
		end
		else if (i_wen)
		begin
			line_sr[0] <= i_pixel;
			for (int k = 1; k < FRAME_WIDTH; k++)
				line_sr[k] <= line_sr[k-1]; // shift one stage per write
		end
	end

	assign o_tap_out = line_sr[FRAME_WIDTH-1]; // same column, previous line

	// newest tap is the pixel being written, so the window includes it
	always_comb
	begin
		taps[WIN_W-1] = i_pixel;
		for (int x = 0; x < WIN_W-1; x++)
			taps[x] = line_sr[WIN_W-2-x];
	end

	// ****************************************
	// horizontal prefix sums
	// ****************************************
	always_comb
	begin
		acc = '0;
		for (int x = 0; x < WIN_W; x++)
		begin
			acc = acc + SUM_W'(taps[x]) + i_col_sum[x]; // columns 0..x
			o_row_integral[x] = acc;
		end
	end

endmodule

`default_nettype wire

//--- source/window_memory.sv
`timescale 1ns/10ps
`default_nettype none

module window_memory
	import window_pkg::*;
(
	input  logic               i_clk,
	input  logic               i_reset,
	input  logic               i_wen,
	input  logic [PIXEL_W-1:0] i_pixel,
	output logic [SUM_W-1:0]   o_integral [WIN_N] // index y*WIN_W + x
);

	// all arrays below indexed by window row y, row 0 oldest
	logic [PIXEL_W-1:0] row_pixel [WIN_H];          // pixel into each line row
	logic [PIXEL_W-1:0] row_tap   [WIN_H];          // delayed pixel out of each row
	logic [SUM_W-1:0]   col_sum   [WIN_H][WIN_W];   // vertical reduction sums
	logic [SUM_W-1:0]   row_int   [WIN_H][WIN_W];   // integral values per row

	// ****************************************
	// line row chain
	// ****************************************
	genvar y;
	generate
		for (y = 0; y < WIN_H; y++)
		begin : gen_row
			if (y == WIN_H-1)
			begin : gen_head
				assign row_pixel[y] = i_pixel; // newest line, fed directly
			end
			else
			begin : gen_chain
				assign row_pixel[y] = row_tap[y+1]; // one line older than row y+1
			end

			line_row u_line_row (
				.i_clk          (i_clk),
				.i_reset        (i_reset),
				.i_wen          (i_wen),
				.i_pixel        (row_pixel[y]),
				.i_col_sum      (col_sum[y]),
				.o_tap_out      (row_tap[y]),
				.o_row_integral (row_int[y])
			);
		end
	endgenerate

	// ****************************************
	// vertical reduction
	// ****************************************
	// row y integral already holds rows 0..y, so the difference of
	// neighbouring entries is the column sum of rows 0..y
	always_comb
	begin
		for (int x = 0; x < WIN_W; x++)
			col_sum[0][x] = '0; // oldest row sees nothing above
		for (int r = 1; r < WIN_H; r++)
		begin
			col_sum[r][0] = row_int[r-1][0];
			for (int x = 1; x < WIN_W; x++)
				col_sum[r][x] = row_int[r-1][x] - row_int[r-1][x-1];
		end
	end

	// output register, holds between writes
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			for (int i = 0; i < WIN_N; i++)
				o_integral[i] <= '0;
		end
		else if (i_wen)
		begin
			for (int r = 0; r < WIN_H; r++)
				for (int x = 0; x < WIN_W; x++)
					o_integral[r*WIN_W + x] <= row_int[r][x];
		end
	end

endmodule

`default_nettype wire

//--- source/fill_control.sv
`timescale 1ns/10ps
`default_nettype none

module fill_control
	import window_pkg::*, ctrl_pkg::*;
(
	input  logic i_clk,
	input  logic i_reset,
	input  logic i_wen,
	input  logic i_sof,          // first pixel of frame, with i_wen
	output logic o_window_valid, // pulse, window fully inside frame
	output logic o_frame_done    // pulse, last pixel written
);

	fill_state_e        state;
	fill_state_e        state_next;
	logic [COL_W-1:0]   col_cnt;    // position of the next pixel
	logic [ROW_W-1:0]   row_cnt;
	logic [COL_W-1:0]   cur_col;    // position of the pixel now written
	logic [ROW_W-1:0]   cur_row;
	logic [COL_W-1:0]   col_next;
	logic [ROW_W-1:0]   row_next;
	logic               last_col;
	logic               last_pix;
	logic               streaming;
	logic               accept;     // write counted in the frame

	// ****************************************
	// frame position
	// ****************************************
	always_comb
	begin
		cur_col   = i_sof ? '0 : col_cnt; // sof restarts at 0,0
		cur_row   = i_sof ? '0 : row_cnt;
		last_col  = (cur_col == COL_W'(FRAME_WIDTH-1));
		last_pix  = last_col && (cur_row == ROW_W'(FRAME_HEIGHT-1));
		streaming = (state == FILL_STREAM) && !i_sof;
		accept    = i_wen && (i_sof || state != FILL_IDLE); // stray writes ignored
		col_next  = cur_col + 1'b1;
		row_next  = cur_row;
		if (last_pix)
		begin
			col_next = '0;
			row_next = '0;
		end
		else if (last_col)
		begin
			col_next = '0;
			row_next = cur_row + 1'b1; // wrap to next line
		end
	end

	// ****************************************
	// fill FSM
	// ****************************************
	always_comb
	begin
		state_next = state;
		if (i_wen)
		begin
			case (state)
				FILL_IDLE:
					if (i_sof)
						state_next = FILL_LINES;
				FILL_LINES:
					if (row_next == ROW_W'(WIN_H-1))
						state_next = FILL_STREAM; // oldest line row now full
				FILL_STREAM:
					if (i_sof)
						state_next = FILL_LINES; // early restart
					else if (last_pix)
						state_next = FILL_IDLE;
				default:
					state_next = FILL_IDLE;
			endcase
		end
	end

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			state          <= FILL_IDLE;
			col_cnt        <= '0;
			row_cnt        <= '0;
			o_window_valid <= 1'b0;
			o_frame_done   <= 1'b0;
		end
		else
		begin
			state <= state_next;
			if (accept)
			begin
				col_cnt <= col_next;
				row_cnt <= row_next;
			end
			// rows >= WIN_H-1 guaranteed by FILL_STREAM
			o_window_valid <= i_wen && streaming && (cur_col >= COL_W'(WIN_W-1));
			o_frame_done   <= i_wen && streaming && last_pix;
		end
	end

endmodule

`default_nettype wire

//--- source/integral_window_top.sv
`timescale 1ns/10ps
`default_nettype none

// ****************************************
// integral window top
// ****************************************
module integral_window_top
	import window_pkg::*;
(
	input  logic               i_clk,
	input  logic               i_reset,
	input  logic [PIXEL_W-1:0] i_pixel,        // camera pixel, raster order
	input  logic               i_wen,          // write strobe, no back-pressure
	input  logic               i_sof,          // start of frame marker
	output logic [SUM_W-1:0]   o_integral [WIN_N],
	output logic               o_window_valid,
	output logic               o_frame_done
);

	// window datapath, line rows and sums
	window_memory u_window_memory (
		.i_clk      (i_clk),
		.i_reset    (i_reset),
		.i_wen      (i_wen),
		.i_pixel    (i_pixel),
		.o_integral (o_integral)
	);

	// frame position and valid flags
	// same write latency as the datapath
	fill_control u_fill_control (
		.i_clk          (i_clk),
		.i_reset        (i_reset),
		.i_wen          (i_wen),
		.i_sof          (i_sof),
		.o_window_valid (o_window_valid),
		.o_frame_done   (o_frame_done)
	);

endmodule

`default_nettype wire

//--- verif/integral_window_asserts.sv
`timescale 1ns/10ps
`default_nettype none

// ****************************************
// fill controller pulse checks
// ****************************************
module integral_window_asserts
(
	input  logic i_clk,
	input  logic i_reset,
	input  logic i_wen,
	input  logic i_window_valid,
	input  logic i_frame_done
);

	int fail_count = 0; // failed assertions so far

	// back to back pulses only with a write behind each
	assert property (@(posedge i_clk) disable iff (i_reset)
		i_window_valid |=> (!i_window_valid || $past(i_wen)))
		else
		begin
			$error("window valid stayed high without a new write");
			fail_count++;
		end

	assert property (@(posedge i_clk) disable iff (i_reset)
		i_frame_done |=> (!i_frame_done || $past(i_wen)))
		else
		begin
			$error("frame done stayed high without a new write");
			fail_count++;
		end

	// cycle after reset, both pulses quiet
	assert property (@(posedge i_clk)
		$past(i_reset) |-> (!i_window_valid && !i_frame_done))
		else
		begin
			$error("controller pulse high right after reset");
			fail_count++;
		end

	// last pixel always sits in a full window
	assert property (@(posedge i_clk) disable iff (i_reset)
		i_frame_done |-> i_window_valid)
		else
		begin
			$error("frame done without window valid");
			fail_count++;
		end

endmodule

`default_nettype wire

//--- verif/integral_window_checker.sv
`timescale 1ns/10ps
`default_nettype none

module integral_window_checker
	import window_pkg::*;
(
	input  logic               i_clk,
	input  logic               i_reset,
	input  logic               i_wen,
	input  logic               i_sof,
	input  logic [PIXEL_W-1:0] i_pixel,
	input  logic               i_exp_valid,        // table flag, same cycle as the write
	input  logic [SUM_W-1:0]   i_integral [WIN_N],
	input  logic               i_window_valid,
	input  logic               i_frame_done,
	output int                 o_value_errors,
	output int                 o_pulse_errors,
	output int                 o_done_count
);

	// newest pixel plus two full lines back covers the window
	localparam int HIST_N = (WIN_H-1)*FRAME_WIDTH + WIN_W;

	logic [PIXEL_W-1:0] hist [HIST_N];  // index 0 newest write
	logic [SUM_W-1:0]   exp_int [WIN_N];
	logic               exp_valid;
	logic               exp_done;
	logic               armed = 1'b0;   // set once an expectation exists
	int                 col;
	int                 row;
	int                 value_errors = 0;
	int                 pulse_errors = 0;
	int                 done_count = 0;

	assign o_value_errors = value_errors;
	assign o_pulse_errors = pulse_errors;
	assign o_done_count   = done_count;

	always @(posedge i_clk)
	begin
		logic [SUM_W-1:0] acc;
		// ****************************************
		// compare, outputs settled since last edge
		// ****************************************
		if (armed)
		begin
			for (int i = 0; i < WIN_N; i++)
				if (i_integral[i] !== exp_int[i])
				begin
					$display("mismatch o_integral[%0d]: expected %h, actual %h",
						i, exp_int[i], i_integral[i]);
					value_errors++;
				end
			if (i_window_valid !== exp_valid)
			begin
				$display("mismatch o_window_valid: expected %h, actual %h",
					exp_valid, i_window_valid);
				pulse_errors++;
			end
			if (i_frame_done !== exp_done)
			begin
				$display("mismatch o_frame_done: expected %h, actual %h",
					exp_done, i_frame_done);
				pulse_errors++;
			end
			if (i_frame_done === 1'b1)
				done_count++;
		end
		// ****************************************
		// expectation for the next edge
		// ****************************************
		if (i_reset)
		begin
			for (int k = 0; k < HIST_N; k++)
				hist[k] = '0;           // line rows cleared
			for (int i = 0; i < WIN_N; i++)
				exp_int[i] = '0;
			exp_valid = 1'b0;
			exp_done  = 1'b0;
			col       = 0;
			row       = 0;
			armed     = 1'b1;
		end
		else if (i_wen)
		begin
			if (i_sof)
			begin
				col = 0;                // frame restarts at 0,0
				row = 0;
			end
			for (int k = HIST_N-1; k > 0; k--)
				hist[k] = hist[k-1];
			hist[0] = i_pixel;
			// window pixel (r,c) lies (WIN_H-1-r) lines and (WIN_W-1-c) pixels back
			for (int y = 0; y < WIN_H; y++)
				for (int x = 0; x < WIN_W; x++)
				begin
					acc = '0;
					for (int r = 0; r <= y; r++)
						for (int c = 0; c <= x; c++)
							acc = acc + SUM_W'(hist[(WIN_H-1-r)*FRAME_WIDTH + (WIN_W-1-c)]);
					exp_int[y*WIN_W + x] = acc;
				end
			exp_valid = i_exp_valid;
			exp_done  = (row == FRAME_HEIGHT-1) && (col == FRAME_WIDTH-1);
			col++;
			if (col == FRAME_WIDTH)
			begin
				col = 0;
				row = (row + 1) % FRAME_HEIGHT; // wraps after the last line
			end
		end
		else
		begin
			exp_valid = 1'b0;           // idle cycle, integrals hold
			exp_done  = 1'b0;
		end
	end

endmodule

`default_nettype wire

//--- verif/tb_integral_window.sv
`timescale 1ns/10ps
`default_nettype none

module tb_integral_window
	import window_pkg::*;
();

	localparam int N_WR      = 2 * FRAME_WIDTH * FRAME_HEIGHT; // two full frames
	localparam int PERIOD    = 100;
	localparam int RESET_CYC = 8;

	logic               i_clk;
	logic               i_reset;
	logic [PIXEL_W-1:0] i_pixel;
	logic               i_wen;
	logic               i_sof;
	logic               exp_valid;       // travels with the write
	logic [SUM_W-1:0]   o_integral [WIN_N];
	logic               o_window_valid;
	logic               o_frame_done;
	int                 value_errors;
	int                 pulse_errors;
	int                 done_count;
	int                 assert_errors;
	int                 other_errors = 0;
	int                 total_cycles;
	logic               table_ready;
	logic [31:0]        lfsr;

	// ****************************************
	// stimulus table
	// ****************************************
	logic               tab_sof   [N_WR];
	logic [PIXEL_W-1:0] tab_pixel [N_WR];
	int                 tab_gap   [N_WR];  // idle cycles after the write
	logic               tab_valid [N_WR];  // expected window valid

	// galois lfsr, one step per bit taken
	function automatic logic lfsr_bit();
		lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
		return lfsr[0];
	endfunction

	function automatic logic [7:0] lfsr_bits(input int n);
		logic [7:0] v;
		v = '0;
		for (int b = 0; b < n; b++)
			v = {v[6:0], lfsr_bit()};
		return v;
	endfunction

	task automatic build_table();
		int col;
		int row;
		total_cycles = RESET_CYC;
		for (int i = 0; i < N_WR; i++)
		begin
			col          = i % FRAME_WIDTH;
			row          = (i / FRAME_WIDTH) % FRAME_HEIGHT;
			tab_sof[i]   = (col == 0) && (row == 0);
			tab_pixel[i] = lfsr_bits(PIXEL_W);
			tab_gap[i]   = int'(lfsr_bits(2)) % 3;  // 0..2 idle cycles
			tab_valid[i] = (row >= WIN_H-1) && (col >= WIN_W-1);
			total_cycles += 1 + tab_gap[i];
		end
	endtask

	initial
	begin
		i_clk = 1'b0;
		forever #(PERIOD/2) i_clk = ~i_clk;
	end

	integral_window_top i_integral_window_top (
		.i_clk          (i_clk),
		.i_reset        (i_reset),
		.i_pixel        (i_pixel),
		.i_wen          (i_wen),
		.i_sof          (i_sof),
		.o_integral     (o_integral),
		.o_window_valid (o_window_valid),
		.o_frame_done   (o_frame_done)
	);

	integral_window_checker u_checker (
		.i_clk          (i_clk),
		.i_reset        (i_reset),
		.i_wen          (i_wen),
		.i_sof          (i_sof),
		.i_pixel        (i_pixel),
		.i_exp_valid    (exp_valid),
		.i_integral     (o_integral),
		.i_window_valid (o_window_valid),
		.i_frame_done   (o_frame_done),
		.o_value_errors (value_errors),
		.o_pulse_errors (pulse_errors),
		.o_done_count   (done_count)
	);

	bind fill_control integral_window_asserts u_asserts (
		.i_clk          (i_clk),
		.i_reset        (i_reset),
		.i_wen          (i_wen),
		.i_window_valid (o_window_valid),
		.i_frame_done   (o_frame_done)
	);

	// watchdog, twice the expected run length
	initial
	begin
		wait (table_ready);
		#(2 * PERIOD * (total_cycles + 4));
		$display("timeout: run still busy after %0d clock cycles", 2 * (total_cycles + 4));
		$display("TESTBENCH FAILED");
		$finish;
	end

	// ****************************************
	// main sequence
	// ****************************************
	initial
	begin
		i_reset     = 1'b1;
		i_pixel     = '0;
		i_wen       = 1'b0;
		i_sof       = 1'b0;
		exp_valid   = 1'b0;
		table_ready = 1'b0;
		lfsr        = 32'h2005_744a;
		build_table();
		table_ready = 1'b1;
		repeat (RESET_CYC) @(posedge i_clk);
		i_reset <= 1'b0;
		for (int i = 0; i < N_WR; i++)
		begin
			@(posedge i_clk);
			i_wen     <= 1'b1;
			i_sof     <= tab_sof[i];
			i_pixel   <= tab_pixel[i];
			exp_valid <= tab_valid[i];
			repeat (tab_gap[i])
			begin
				@(posedge i_clk);
				i_wen     <= 1'b0; // gap, outputs must hold
				i_sof     <= 1'b0;
				exp_valid <= 1'b0;
			end
		end
		@(posedge i_clk);
		i_wen     <= 1'b0;
		i_sof     <= 1'b0;
		exp_valid <= 1'b0;
		repeat (3) @(posedge i_clk); // last write still to be compared
		if (done_count != 2)
		begin
			$display("frame done pulsed %0d times over two frames", done_count);
			other_errors++;
		end
		assert_errors = i_integral_window_top.u_fill_control.u_asserts.fail_count;
		$display("errors: %0d value, %0d pulse, %0d assertion, %0d other",
			value_errors, pulse_errors, assert_errors, other_errors);
		if (value_errors + pulse_errors + assert_errors + other_errors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- sim.f
source/window_pkg.sv
source/ctrl_pkg.sv
source/line_row.sv
source/window_memory.sv
source/fill_control.sv
source/integral_window_top.sv
verif/integral_window_asserts.sv
verif/integral_window_checker.sv
verif/tb_integral_window.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_integral_window
FILELIST = sim.f
BUILD    = obj_dir
LOG      = sim.log
PASS_MSG = TESTBENCH PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with $(TOOL), run $(TOP), search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD) and $(LOG)"
	@echo "  help   this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation ok"; \
	else \
		echo "simulation reported failure"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)
